/* rtl/ddr3_app_pkg.sv */
`default_nettype none

package ddr3_app_pkg;

        // controller command encoding, as seen on app_cmd
        typedef enum logic [2:0] {
                CMD_WR = 3'b000,
                CMD_RD = 3'b001
        } app_cmd_e;

        // application address: {rank, bank, row/column}
        localparam int APP_ADDR_W = 28;
        typedef logic [APP_ADDR_W-1:0] app_addr_t;

        // one user data word, write or read side
        localparam int APP_DATA_W = 128;
        typedef logic [APP_DATA_W-1:0] app_data_t;

endpackage : ddr3_app_pkg

`default_nettype wire

/* rtl/tg_pkg.sv */
`default_nettype none

package tg_pkg;

        localparam int BANK_W = 3;
        typedef logic [BANK_W-1:0] bank_t;

        localparam int COL_W = 24;
        typedef logic [COL_W-1:0] col_t;

        // phase of the test sequence
        typedef enum logic [1:0] {
                ST_IDLE,
                ST_WRITE,
                ST_READ
        } tg_state_e;

        localparam int ROUND_W = 16;
        typedef logic [ROUND_W-1:0] round_t;

        // pattern fields inside the data word
        localparam int PAT_BANK_W = 8;
        localparam int PAT_BEAT_W = 16;
        typedef logic [PAT_BEAT_W-1:0] beat_t;

        // bank number on top, beat index at the bottom, zeros between
        function automatic ddr3_app_pkg::app_data_t make_pattern(bank_t b, beat_t beat);
                ddr3_app_pkg::app_data_t w;
                w = '0;
                w[ddr3_app_pkg::APP_DATA_W-1 -: PAT_BANK_W] = PAT_BANK_W'(b);
                w[PAT_BEAT_W-1:0] = beat;
                return w;
        endfunction

endpackage : tg_pkg

`default_nettype wire

/* rtl/tg_phase_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module tg_phase_fsm #(
        parameter int NUM_BANKS = 8
) (
        input  logic              ui_clk,
        input  logic              ui_clk_sync_rst,
        input  logic              init_calib_complete,
        input  logic              bank_done,
        output tg_pkg::tg_state_e phase,
        output tg_pkg::bank_t     bank
);

        import tg_pkg::*;

        tg_state_e state;
        tg_state_e state_nxt;
        bank_t     bank_q;
        logic      last_bank;

        // wrap point of the bank counter
        assign last_bank = (bank_q == bank_t'(NUM_BANKS - 1));

        // ********************
        // phase state
        // ********************

        always_comb begin
                state_nxt = state;
                case (state)
                        ST_IDLE: begin
                                // start writing once the controller is calibrated
                                if (init_calib_complete) begin
                                        state_nxt = ST_WRITE;
                                end
                        end
                        ST_WRITE: begin
                                if (bank_done && last_bank) begin
                                        state_nxt = ST_READ;
                                end
                        end
                        ST_READ: begin
                                // back to writing bank 0, next round
                                if (bank_done && last_bank) begin
                                        state_nxt = ST_WRITE;
                                end
                        end
                        default: begin
                                state_nxt = ST_IDLE;
                        end
                endcase
        end

        always_ff @(posedge ui_clk or posedge ui_clk_sync_rst) begin
                if (ui_clk_sync_rst) begin
                        state <= ST_IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        // ********************
        // bank counter
        // ********************

        // steps right at the bank_done edge, no gap between banks
        always_ff @(posedge ui_clk or posedge ui_clk_sync_rst) begin
                if (ui_clk_sync_rst) begin
                        bank_q <= '0;
                end else if (bank_done) begin
                        if (last_bank) begin
                                bank_q <= '0;
                        end else begin
                                bank_q <= bank_q + bank_t'(1);
                        end
                end
        end

        assign phase = state;
        assign bank  = bank_q;

endmodule : tg_phase_fsm

`default_nettype wire

/* rtl/tg_cmd_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tg_cmd_gen #(
        parameter int COL_STRIDE = 8,
        parameter int COL_LIMIT  = 800
) (
        input  logic                    ui_clk,
        input  logic                    ui_clk_sync_rst,
        input  tg_pkg::tg_state_e       phase,
        input  tg_pkg::bank_t           bank,
        input  logic                    app_rdy,
        input  logic                    app_wdf_rdy,
        output logic                    app_en,
        output ddr3_app_pkg::app_cmd_e  app_cmd,
        output ddr3_app_pkg::app_addr_t app_addr,
        output logic                    app_wdf_wren,
        output logic                    app_wdf_end,
        output ddr3_app_pkg::app_data_t app_wdf_data,
        output logic                    bank_done
);

        import ddr3_app_pkg::*;
        import tg_pkg::*;

        localparam col_t LAST_COL = col_t'(COL_LIMIT - COL_STRIDE);

        col_t  col;
        beat_t beat;
        logic  wr_go;
        logic  rd_go;
        logic  accept;

        // ********************
        // command handshake
        // ********************

        // write needs both command and write data FIFO space
        assign wr_go  = (phase == ST_WRITE) && app_rdy && app_wdf_rdy;
        assign rd_go  = (phase == ST_READ) && app_rdy;
        assign accept = wr_go || rd_go;

        assign app_en       = accept;
        assign app_wdf_wren = wr_go;
        // single beat per command, so end follows wren
        assign app_wdf_end  = wr_go;

        always_comb begin
                if (phase == ST_READ) begin
                        app_cmd = CMD_RD;
                end else begin
                        app_cmd = CMD_WR;
                end
        end

        assign bank_done = accept && (col == LAST_COL);

        // ********************
        // column and beat counters
        // ********************

        // beat tracks col / COL_STRIDE without a divider
        always_ff @(posedge ui_clk or posedge ui_clk_sync_rst) begin
                if (ui_clk_sync_rst) begin
                        col  <= '0;
                        beat <= '0;
                end else if (bank_done) begin
                        col  <= '0;
                        beat <= '0;
                end else if (accept) begin
                        col  <= col + col_t'(COL_STRIDE);
                        beat <= beat + beat_t'(1);
                end
        end

        // address is {0, bank, column}
        assign app_addr = {1'b0, bank, col};

        assign app_wdf_data = make_pattern(bank, beat);

endmodule : tg_cmd_gen

`default_nettype wire

/* rtl/tg_rd_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tg_rd_checker #(
        parameter int NUM_BANKS  = 8,
        parameter int COL_LIMIT  = 800,
        parameter int COL_STRIDE = 8
) (
        input  logic                    ui_clk,
        input  logic                    ui_clk_sync_rst,
        input  ddr3_app_pkg::app_data_t app_rd_data,
        input  logic                    app_rd_data_valid,
        output logic                    tg_compare_error,
        output tg_pkg::round_t          round_count
);

        import ddr3_app_pkg::*;
        import tg_pkg::*;

        // read beats per bank in one pass
        localparam int BEATS = COL_LIMIT / COL_STRIDE;

        bank_t     exp_bank;
        beat_t     exp_beat;
        app_data_t exp_data;
        logic      mismatch;
        logic      last_beat;
        logic      last_bank;

        // ********************
        // expected word
        // ********************

        assign exp_data  = make_pattern(exp_bank, exp_beat);
        assign mismatch  = app_rd_data_valid && (app_rd_data != exp_data);
        assign last_beat = (exp_beat == beat_t'(BEATS - 1));
        assign last_bank = (exp_bank == bank_t'(NUM_BANKS - 1));

        // data comes back in command order, so just count along
        always_ff @(posedge ui_clk or posedge ui_clk_sync_rst) begin
                if (ui_clk_sync_rst) begin
                        exp_bank <= '0;
                        exp_beat <= '0;
                end else if (app_rd_data_valid) begin
                        if (last_beat) begin
                                exp_beat <= '0;
                                if (last_bank) begin
                                        exp_bank <= '0;
                                end else begin
                                        exp_bank <= exp_bank + bank_t'(1);
                                end
                        end else begin
                                exp_beat <= exp_beat + beat_t'(1);
                        end
                end
        end

        // ********************
        // result
        // ********************

        // sticky until reset
        always_ff @(posedge ui_clk or posedge ui_clk_sync_rst) begin
                if (ui_clk_sync_rst) begin
                        tg_compare_error <= 1'b0;
                end else if (mismatch) begin
                        tg_compare_error <= 1'b1;
                end
        end

        // one round = every beat of every bank read back
        always_ff @(posedge ui_clk or posedge ui_clk_sync_rst) begin
                if (ui_clk_sync_rst) begin
                        round_count <= '0;
                end else if (app_rd_data_valid && last_beat && last_bank) begin
                        round_count <= round_count + round_t'(1);
                end
        end

endmodule : tg_rd_checker

`default_nettype wire

/* rtl/ddr3_traffic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_traffic_top #(
        parameter int NUM_BANKS  = 8,
        parameter int COL_STRIDE = 8,
        parameter int COL_LIMIT  = 800
) (
        input  logic                    ui_clk,
        input  logic                    ui_clk_sync_rst,

        // from the memory controller
        input  logic                    init_calib_complete,
        input  logic                    app_rdy,
        input  logic                    app_wdf_rdy,
        input  ddr3_app_pkg::app_data_t app_rd_data,
        input  logic                    app_rd_data_valid,

        // to the memory controller
        output logic                    app_en,
        output ddr3_app_pkg::app_cmd_e  app_cmd,
        output ddr3_app_pkg::app_addr_t app_addr,
        output logic                    app_wdf_wren,
        output ddr3_app_pkg::app_data_t app_wdf_data,
        output logic                    app_wdf_end,

        // status
        output logic                    tg_compare_error,
        output tg_pkg::round_t          round_count
);

        import tg_pkg::*;

        tg_state_e phase;
        bank_t     bank;
        logic      bank_done;

        // ********************
        // decode
        // ********************

        tg_phase_fsm #(
                .NUM_BANKS (NUM_BANKS)
        ) u_phase_fsm (
                .ui_clk              (ui_clk),
                .ui_clk_sync_rst     (ui_clk_sync_rst),
                .init_calib_complete (init_calib_complete),
                .bank_done           (bank_done),
                .phase               (phase),
                .bank                (bank)
        );

        // ********************
        // execute
        // ********************

        tg_cmd_gen #(
                .COL_STRIDE (COL_STRIDE),
                .COL_LIMIT  (COL_LIMIT)
        ) u_cmd_gen (
                .ui_clk          (ui_clk),
                .ui_clk_sync_rst (ui_clk_sync_rst),
                .phase           (phase),
                .bank            (bank),
                .app_rdy         (app_rdy),
                .app_wdf_rdy     (app_wdf_rdy),
                .app_en          (app_en),
                .app_cmd         (app_cmd),
                .app_addr        (app_addr),
                .app_wdf_wren    (app_wdf_wren),
                .app_wdf_end     (app_wdf_end),
                .app_wdf_data    (app_wdf_data),
                .bank_done       (bank_done)
        );

        // ********************
        // result
        // ********************

        // only sees the read return path
        tg_rd_checker #(
                .NUM_BANKS  (NUM_BANKS),
                .COL_LIMIT  (COL_LIMIT),
                .COL_STRIDE (COL_STRIDE)
        ) u_rd_checker (
                .ui_clk            (ui_clk),
                .ui_clk_sync_rst   (ui_clk_sync_rst),
                .app_rd_data       (app_rd_data),
                .app_rd_data_valid (app_rd_data_valid),
                .tg_compare_error  (tg_compare_error),
                .round_count       (round_count)
        );

endmodule : ddr3_traffic_top

`default_nettype wire

/* sim/tb_app_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_app_model (
        input  logic                    ui_clk,
        input  logic                    ui_clk_sync_rst,
        input  logic                    app_en,
        input  ddr3_app_pkg::app_cmd_e  app_cmd,
        input  ddr3_app_pkg::app_addr_t app_addr,
        input  logic                    app_wdf_wren,
        input  ddr3_app_pkg::app_data_t app_wdf_data,
        input  logic                    inject_fault,
        output logic                    app_rdy,
        output logic                    app_wdf_rdy,
        output ddr3_app_pkg::app_data_t app_rd_data,
        output logic                    app_rd_data_valid
);

        import ddr3_app_pkg::*;

        integer    seed;
        int        cycle;
        logic      fault_used;
        app_data_t word;
        app_data_t mem [app_addr_t];
        app_addr_t rd_addr_q [$];
        int        rd_due_q [$];

        initial begin
                seed              = 49841;
                cycle             = 0;
                fault_used        = 1'b0;
                app_rdy           = 1'b0;
                app_wdf_rdy       = 1'b0;
                app_rd_data       = '0;
                app_rd_data_valid = 1'b0;
        end

        always @(negedge ui_clk) begin
                cycle = cycle + 1;
                // ready roughly three cycles in four
                app_rdy     = (($random(seed) & 3) != 0);
                app_wdf_rdy = (($random(seed) & 3) != 0);

                // read return, strictly in command order
                app_rd_data_valid = 1'b0;
                if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
                        word = '0;
                        if (mem.exists(rd_addr_q[0])) begin
                                word = mem[rd_addr_q[0]];
                        end
                        // one flipped bit per request
                        if (inject_fault && !fault_used) begin
                                word[5]    = ~word[5];
                                fault_used = 1'b1;
                        end
                        app_rd_data       = word;
                        app_rd_data_valid = 1'b1;
                        void'(rd_addr_q.pop_front());
                        void'(rd_due_q.pop_front());
                end
                if (!inject_fault) begin
                        fault_used = 1'b0;
                end

                // command stays put until the next rising edge accepts it
                #1;
                if (!ui_clk_sync_rst && app_en) begin
                        if (app_wdf_wren) begin
                                mem[app_addr] = app_wdf_data;
                        end else if (app_cmd == CMD_RD) begin
                                rd_addr_q.push_back(app_addr);
                                rd_due_q.push_back(cycle + 3 + ($random(seed) & 15));
                        end
                end
        end

endmodule : tb_app_model

`default_nettype wire

/* sim/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

        import ddr3_app_pkg::*;
        import tg_pkg::*;

        localparam int NUM_BANKS  = 8;
        localparam int COL_STRIDE = 8;
        localparam int COL_LIMIT  = 800;
        localparam int PASS_CMDS  = NUM_BANKS * COL_LIMIT / COL_STRIDE;
        localparam int WAIT_LIMIT = 20000;

        logic      ui_clk, ui_clk_sync_rst, init_calib_complete, inject_fault;
        logic      app_rdy, app_wdf_rdy, app_rd_data_valid;
        logic      app_en, app_wdf_wren, app_wdf_end, tg_compare_error;
        app_cmd_e  app_cmd;
        app_addr_t app_addr;
        app_data_t app_wdf_data, app_rd_data;
        round_t    round_count;

        int        err_count, pass_count, fail_count, e0, e_calib, n;
        int        bp_errs, stall_cycles, writes_seen, reads_seen, mon_e0, exp_col;
        logic      mon_en, exp_rd;
        bank_t     exp_bank;
        string     timeout_what;

        initial ui_clk = 1'b0;
        always #4 ui_clk = ~ui_clk;

        ddr3_traffic_top #(
                .NUM_BANKS (NUM_BANKS), .COL_STRIDE (COL_STRIDE), .COL_LIMIT (COL_LIMIT)
        ) u_dut (
                .ui_clk (ui_clk), .ui_clk_sync_rst (ui_clk_sync_rst),
                .init_calib_complete (init_calib_complete), .app_rdy (app_rdy),
                .app_wdf_rdy (app_wdf_rdy), .app_rd_data (app_rd_data),
                .app_rd_data_valid (app_rd_data_valid), .app_en (app_en),
                .app_cmd (app_cmd), .app_addr (app_addr), .app_wdf_wren (app_wdf_wren),
                .app_wdf_data (app_wdf_data), .app_wdf_end (app_wdf_end),
                .tg_compare_error (tg_compare_error), .round_count (round_count)
        );

        tb_app_model u_model (
                .ui_clk (ui_clk), .ui_clk_sync_rst (ui_clk_sync_rst), .app_en (app_en),
                .app_cmd (app_cmd), .app_addr (app_addr), .app_wdf_wren (app_wdf_wren),
                .app_wdf_data (app_wdf_data), .inject_fault (inject_fault),
                .app_rdy (app_rdy), .app_wdf_rdy (app_wdf_rdy),
                .app_rd_data (app_rd_data), .app_rd_data_valid (app_rd_data_valid)
        );

        // ********************
        // reference model and compare tasks
        // ********************

        function automatic app_addr_t exp_addr(bank_t b, int col);
                return {1'b0, b, col_t'(col)};
        endfunction

        // bank in the top byte, beat index in the low 16 bits
        function automatic app_data_t exp_word(bank_t b, int col);
                app_data_t w;
                w = '0;
                w[127:120] = 8'(b);
                w[15:0]    = 16'(col / COL_STRIDE);
                return w;
        endfunction

        task automatic check_cmd(string name, app_cmd_e exp, app_cmd_e act);
                if (act !== exp) begin
                        err_count++;
                        $display("ERROR at %0t ns: %s expected %0d, got %0d",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_addr(string name, app_addr_t exp, app_addr_t act);
                if (act !== exp) begin
                        err_count++;
                        $display("ERROR at %0t ns: %s expected 0x%h, got 0x%h",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_data(string name, app_data_t exp, app_data_t act);
                if (act !== exp) begin
                        err_count++;
                        $display("ERROR at %0t ns: %s expected 0x%h, got 0x%h",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_flag(string name, logic exp, logic act);
                if (act !== exp) begin
                        err_count++;
                        $display("ERROR at %0t ns: %s expected %b, got %b",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_count(string name, round_t exp, round_t act);
                if (act !== exp) begin
                        err_count++;
                        $display("ERROR at %0t ns: %s expected %0d, got %0d",
                                 $time, name, exp, act);
                end
        endtask

        task automatic report_test(string name, bit ok);
                if (ok) begin
                        pass_count++;
                        $display("[pass] %s", name);
                end else begin
                        fail_count++;
                        $display("[fail] %s", name);
                end
        endtask

        // command monitor, sampled after the model has driven ready
        always @(negedge ui_clk) begin
                #2;
                if (mon_en) begin
                        mon_e0 = err_count;
                        if (!app_rdy || (!exp_rd && !app_wdf_rdy)) begin
                                stall_cycles++;
                                check_flag("app_en", 1'b0, app_en);
                        end
                        if (err_count != mon_e0) bp_errs++;
                        // write strobes only together with an accepted write
                        if (!app_en || exp_rd) begin
                                check_flag("app_wdf_wren", 1'b0, app_wdf_wren);
                                check_flag("app_wdf_end", 1'b0, app_wdf_end);
                        end
                        if (app_en) begin
                                check_cmd("app_cmd", exp_rd ? CMD_RD : CMD_WR, app_cmd);
                                check_addr("app_addr", exp_addr(exp_bank, exp_col), app_addr);
                                if (exp_rd) begin
                                        reads_seen++;
                                end else begin
                                        writes_seen++;
                                        check_flag("app_wdf_wren", 1'b1, app_wdf_wren);
                                        check_flag("app_wdf_end", 1'b1, app_wdf_end);
                                        check_data("app_wdf_data", exp_word(exp_bank, exp_col),
                                                   app_wdf_data);
                                end
                                exp_col += COL_STRIDE;
                                if (exp_col == COL_LIMIT) begin
                                        exp_col = 0;
                                        if (exp_bank == bank_t'(NUM_BANKS - 1)) exp_rd = ~exp_rd;
                                        exp_bank = exp_bank + bank_t'(1);
                                end
                        end
                end
        end

        // ********************
        // test sequence
        // ********************

        initial begin
                ui_clk_sync_rst = 1'b1;
                init_calib_complete = 1'b0;
                inject_fault = 1'b0;
                mon_en = 1'b0;
                exp_rd = 1'b0;
                exp_bank = '0;
                exp_col = 0;
                err_count = 0;
                pass_count = 0;
                fail_count = 0;
                bp_errs = 0;
                stall_cycles = 0;
                writes_seen = 0;
                reads_seen = 0;
                timeout_what = "";
                begin : run_tests
                        e0 = err_count;
                        for (n = 0; n < 30; n++) begin
                                @(negedge ui_clk);
                                if (n == 10) ui_clk_sync_rst = 1'b0;
                                #2;
                                check_flag("app_en", 1'b0, app_en);
                                check_flag("app_wdf_wren", 1'b0, app_wdf_wren);
                                check_flag("tg_compare_error", 1'b0, tg_compare_error);
                                check_count("round_count", '0, round_count);
                        end
                        report_test("reset", err_count == e0);

                        @(negedge ui_clk);
                        init_calib_complete = 1'b1;
                        mon_en = 1'b1;
                        e0 = err_count;
                        e_calib = err_count;
                        n = 0;
                        while (writes_seen < PASS_CMDS && n < WAIT_LIMIT) begin
                                @(negedge ui_clk);
                                #3 n++;
                        end
                        if (writes_seen < PASS_CMDS) begin
                                timeout_what = "write pass";
                                disable run_tests;
                        end
                        report_test("write pass", err_count == e0);

                        e0 = err_count;
                        n = 0;
                        while (reads_seen < PASS_CMDS && n < WAIT_LIMIT) begin
                                @(negedge ui_clk);
                                #3 n++;
                        end
                        if (reads_seen < PASS_CMDS) begin
                                timeout_what = "read pass";
                                disable run_tests;
                        end
                        report_test("read pass", err_count == e0);
                        report_test("back-pressure", bp_errs == 0 && stall_cycles > 0);

                        n = 0;
                        while (round_count < 2 && n < WAIT_LIMIT) begin
                                @(negedge ui_clk);
                                #3 n++;
                        end
                        if (round_count < 2) begin
                                timeout_what = "round completion";
                                disable run_tests;
                        end
                        check_count("round_count", 16'd2, round_count);
                        check_flag("tg_compare_error", 1'b0, tg_compare_error);
                        report_test("clean rounds", err_count == e_calib);

                        // corrupt one returned word in the third read pass
                        e0 = err_count;
                        n = 0;
                        while (!exp_rd && n < WAIT_LIMIT) begin
                                @(negedge ui_clk);
                                #3 n++;
                                check_flag("tg_compare_error", 1'b0, tg_compare_error);
                        end
                        if (!exp_rd) begin
                                timeout_what = "third read pass";
                                disable run_tests;
                        end
                        inject_fault = 1'b1;
                        n = 0;
                        while (tg_compare_error !== 1'b1 && n < WAIT_LIMIT) begin
                                @(negedge ui_clk);
                                #3 n++;
                        end
                        if (tg_compare_error !== 1'b1) begin
                                timeout_what = "compare error";
                                disable run_tests;
                        end
                        inject_fault = 1'b0;
                        n = 0;
                        while (round_count < 4 && n < WAIT_LIMIT) begin
                                @(negedge ui_clk);
                                #3 n++;
                                check_flag("tg_compare_error", 1'b1, tg_compare_error);
                        end
                        if (round_count < 4) begin
                                timeout_what = "round after fault";
                                disable run_tests;
                        end
                        report_test("fault detection", err_count == e0);
                end

                if (timeout_what != "") begin
                        $display("timeout waiting for %s", timeout_what);
                        $display("tests passed: %0d, failed: %0d", pass_count, fail_count + 1);
                        $display("TEST FAILED");
                end else begin
                        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
                        if (fail_count == 0) begin
                                $display("TEST OK");
                        end else begin
                                $display("TEST FAILED");
                        end
                end
                $finish;
        end

endmodule : tb_top

`default_nettype wire

/* ddr3_traffic.f */
rtl/ddr3_app_pkg.sv
rtl/tg_pkg.sv
rtl/tg_phase_fsm.sv
rtl/tg_cmd_gen.sv
rtl/tg_rd_checker.sv
rtl/ddr3_traffic_top.sv
sim/tb_app_model.sv
sim/tb_top.sv
